// ==== hdl/box_plotter.sv ====
`timescale 1ns/1ps

module box_plotter #(
	parameter int BOX_W = 4,
	parameter int BOX_H = 4
) (
	input  logic               clk,
	input  logic               resetn,
	input  logic               start,
	input  pong_pkg::coord_x_t origin_x,
	input  pong_pkg::coord_y_t origin_y,
	output pong_pkg::coord_x_t px,
	output pong_pkg::coord_y_t py,
	output logic               active,
	output logic               done
);

	import pong_pkg::*;

	localparam int CW = $clog2(BOX_W + 1);
	localparam int RW = $clog2(BOX_H + 1);

	coord_x_t org_x;
	coord_y_t org_y;
	logic [CW-1:0] col;
	logic [RW-1:0] row;
	logic last_col;
	logic last_row;

	assign last_col = (col == CW'(BOX_W - 1));
	assign last_row = (row == RW'(BOX_H - 1));

	always_ff @(posedge clk) begin
		if (start) begin
			org_x <= origin_x;
			org_y <= origin_y;
		end
	end

	// row by row, left to right
	always_ff @(posedge clk) begin
		if (!resetn) begin
			active <= 1'b0;
			col <= '0;
			row <= '0;
		end else if (start) begin
			active <= 1'b1;
			col <= '0;
			row <= '0;
		end else if (active) begin
			if (last_col) begin
				col <= '0;
				if (last_row) begin
					active <= 1'b0;
				end else begin
					row <= row + 1'b1;
				end
			end else begin
				col <= col + 1'b1;
			end
		end
	end

	assign px = org_x + coord_x_t'(col);
	assign py = org_y + coord_y_t'(row);
	assign done = active && last_col && last_row;

	a_start_idle: assert property (@(posedge clk) disable iff (!resetn)
		start |-> !active);

endmodule

// ==== hdl/frame_timer.sv ====
`timescale 1ns/1ps

module frame_timer #(
	parameter int CLOCKS_PER_FRAME = 833333
) (
	input  logic clk,
	input  logic resetn,
	output logic frame_tick
);

	localparam int CW = $clog2(CLOCKS_PER_FRAME + 1);

	logic [CW-1:0] count;

	// down-counter, tick registered on the reload cycle
	always_ff @(posedge clk) begin
		if (!resetn) begin
			count <= CW'(CLOCKS_PER_FRAME - 1);
			frame_tick <= 1'b0;
		end else if (count == '0) begin
			count <= CW'(CLOCKS_PER_FRAME - 1);
			frame_tick <= 1'b1;
		end else begin
			count <= count - 1'b1;
			frame_tick <= 1'b0;
		end
	end

	a_tick_single: assert property (@(posedge clk) disable iff (!resetn)
		frame_tick |=> !frame_tick);

endmodule

// ==== hdl/pixel_output.sv ====
`timescale 1ns/1ps

module pixel_output (
	input  logic                 clk,
	input  logic                 resetn,
	input  pong_pkg::draw_step_t step,
	input  pong_pkg::coord_x_t   fill_px,
	input  pong_pkg::coord_y_t   fill_py,
	input  logic                 fill_active,
	input  pong_pkg::coord_x_t   paddle_px,
	input  pong_pkg::coord_y_t   paddle_py,
	input  logic                 paddle_active,
	input  pong_pkg::coord_x_t   ball_px,
	input  pong_pkg::coord_y_t   ball_py,
	input  logic                 ball_active,
	output pong_pkg::coord_x_t   pix_x,
	output pong_pkg::coord_y_t   pix_y,
	output pong_pkg::colour_t    pix_colour,
	output logic                 plot
);

	import pong_pkg::*;

	coord_x_t sel_x;
	coord_y_t sel_y;
	colour_t sel_colour;

	always_comb begin
		if (fill_active) begin
			sel_x = fill_px;
			sel_y = fill_py;
		end else if (paddle_active) begin
			sel_x = paddle_px;
			sel_y = paddle_py;
		end else begin
			sel_x = ball_px;
			sel_y = ball_py;
		end
	end

	// clears and erases are black, so an aborted box blanks out too
	always_comb begin
		case (step)
			S_DRAW_P1, S_DRAW_P2: sel_colour = COLOUR_PADDLE;
			S_DRAW_BALL:          sel_colour = COLOUR_BALL;
			default:              sel_colour = COLOUR_BLACK;
		endcase
	end

	always_ff @(posedge clk) begin
		pix_x <= sel_x;
		pix_y <= sel_y;
		pix_colour <= sel_colour;
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			plot <= 1'b0;
		end else begin
			plot <= fill_active | paddle_active | ball_active;
		end
	end

	a_one_engine: assert property (@(posedge clk) disable iff (!resetn)
		$onehot0({fill_active, paddle_active, ball_active}));

endmodule

// ==== hdl/pong_display.sv ====
`timescale 1ns/1ps

module pong_display #(
	parameter int SCREEN_W         = 320,
	parameter int SCREEN_H         = 240,
	parameter int PADDLE_W         = 5,
	parameter int PADDLE_H         = 40,
	parameter int BALL_W           = 4,
	parameter int BALL_H           = 4,
	parameter int PADDLE1_X        = 2,
	parameter int CLOCKS_PER_FRAME = 833333
) (
	input  logic               clk,
	input  logic               resetn,
	input  logic               scored,
	input  pong_pkg::coord_y_t paddle1_y,
	input  pong_pkg::coord_y_t paddle2_y,
	input  pong_pkg::coord_x_t ball_x,
	input  pong_pkg::coord_y_t ball_y,
	output pong_pkg::coord_x_t pix_x,
	output pong_pkg::coord_y_t pix_y,
	output pong_pkg::colour_t  pix_colour,
	output logic               plot
);

	import pong_pkg::*;

	logic frame_tick;
	draw_step_t step;
	logic frame_latch;
	logic fill_start, paddle_start, ball_start;
	logic fill_done, paddle_done, ball_done;
	logic fill_active, paddle_active, ball_active;
	coord_x_t origin_x, fill_px, paddle_px, ball_px;
	coord_y_t origin_y, fill_py, paddle_py, ball_py;

	frame_timer #(.CLOCKS_PER_FRAME(CLOCKS_PER_FRAME)) frame_timer_inst (
		.clk(clk), .resetn(resetn), .frame_tick(frame_tick)
	);

	render_sequencer render_sequencer_inst (
		.clk(clk), .resetn(resetn), .scored(scored), .frame_tick(frame_tick),
		.fill_done(fill_done), .paddle_done(paddle_done), .ball_done(ball_done),
		.step(step), .frame_latch(frame_latch), .fill_start(fill_start),
		.paddle_start(paddle_start), .ball_start(ball_start)
	);

	position_store #(.SCREEN_W(SCREEN_W), .PADDLE_W(PADDLE_W), .PADDLE1_X(PADDLE1_X))
	position_store_inst (
		.clk(clk), .resetn(resetn), .frame_latch(frame_latch), .step(step),
		.paddle1_y(paddle1_y), .paddle2_y(paddle2_y), .ball_x(ball_x), .ball_y(ball_y),
		.origin_x(origin_x), .origin_y(origin_y)
	);

	screen_filler #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H)) screen_filler_inst (
		.clk(clk), .resetn(resetn), .start(fill_start),
		.px(fill_px), .py(fill_py), .active(fill_active), .done(fill_done)
	);

	// both paddles share one engine, the ball has its own
	box_plotter #(.BOX_W(PADDLE_W), .BOX_H(PADDLE_H)) paddle_plotter (
		.clk(clk), .resetn(resetn), .start(paddle_start),
		.origin_x(origin_x), .origin_y(origin_y),
		.px(paddle_px), .py(paddle_py), .active(paddle_active), .done(paddle_done)
	);

	box_plotter #(.BOX_W(BALL_W), .BOX_H(BALL_H)) ball_plotter (
		.clk(clk), .resetn(resetn), .start(ball_start),
		.origin_x(origin_x), .origin_y(origin_y),
		.px(ball_px), .py(ball_py), .active(ball_active), .done(ball_done)
	);

	pixel_output pixel_output_inst (
		.clk(clk), .resetn(resetn), .step(step),
		.fill_px(fill_px), .fill_py(fill_py), .fill_active(fill_active),
		.paddle_px(paddle_px), .paddle_py(paddle_py), .paddle_active(paddle_active),
		.ball_px(ball_px), .ball_py(ball_py), .ball_active(ball_active),
		.pix_x(pix_x), .pix_y(pix_y), .pix_colour(pix_colour), .plot(plot)
	);

endmodule

// ==== hdl/pong_pkg.sv ====
package pong_pkg;

	// screen coordinates, sized for up to 1024 x 512
	typedef logic [9:0] coord_x_t;
	typedef logic [8:0] coord_y_t;

	// 3-bit rgb
	typedef logic [2:0] colour_t;

	// render sequencer states
	// erase steps use the previous snapshot, draw steps the current one
	typedef enum logic [3:0] {
		S_CLEAR_START,
		S_CLEAR_WAIT,
		S_IDLE,
		S_ERASE_P1,
		S_DRAW_P1,
		S_ERASE_P2,
		S_DRAW_P2,
		S_ERASE_BALL,
		S_DRAW_BALL
	} draw_step_t;

	localparam colour_t COLOUR_BLACK  = 3'd0;
	// white
	localparam colour_t COLOUR_PADDLE = 3'd7;
	// yellow
	localparam colour_t COLOUR_BALL   = 3'd6;

endpackage

// ==== hdl/position_store.sv ====
`timescale 1ns/1ps

module position_store #(
	parameter int SCREEN_W  = 320,
	parameter int PADDLE_W  = 5,
	parameter int PADDLE1_X = 2
) (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 frame_latch,
	input  pong_pkg::draw_step_t step,
	input  pong_pkg::coord_y_t   paddle1_y,
	input  pong_pkg::coord_y_t   paddle2_y,
	input  pong_pkg::coord_x_t   ball_x,
	input  pong_pkg::coord_y_t   ball_y,
	output pong_pkg::coord_x_t   origin_x,
	output pong_pkg::coord_y_t   origin_y
);

	import pong_pkg::*;

	localparam coord_x_t P1_X = coord_x_t'(PADDLE1_X);
	// right paddle sits flush against the right edge
	localparam coord_x_t P2_X = coord_x_t'(SCREEN_W - PADDLE_W);

	coord_y_t cur_p1_y, cur_p2_y, cur_ball_y;
	coord_y_t prev_p1_y, prev_p2_y, prev_ball_y;
	coord_x_t cur_ball_x, prev_ball_x;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			cur_p1_y <= '0;
			cur_p2_y <= '0;
			cur_ball_x <= '0;
			cur_ball_y <= '0;
			prev_p1_y <= '0;
			prev_p2_y <= '0;
			prev_ball_x <= '0;
			prev_ball_y <= '0;
		end else if (frame_latch) begin
			prev_p1_y <= cur_p1_y;
			prev_p2_y <= cur_p2_y;
			prev_ball_x <= cur_ball_x;
			prev_ball_y <= cur_ball_y;
			cur_p1_y <= paddle1_y;
			cur_p2_y <= paddle2_y;
			cur_ball_x <= ball_x;
			cur_ball_y <= ball_y;
		end
	end

	always_comb begin
		case (step)
			S_ERASE_P1:   begin origin_x = P1_X;        origin_y = prev_p1_y;   end
			S_DRAW_P1:    begin origin_x = P1_X;        origin_y = cur_p1_y;    end
			S_ERASE_P2:   begin origin_x = P2_X;        origin_y = prev_p2_y;   end
			S_DRAW_P2:    begin origin_x = P2_X;        origin_y = cur_p2_y;    end
			S_ERASE_BALL: begin origin_x = prev_ball_x; origin_y = prev_ball_y; end
			S_DRAW_BALL:  begin origin_x = cur_ball_x;  origin_y = cur_ball_y;  end
			default:      begin origin_x = '0;          origin_y = '0;          end
		endcase
	end

endmodule

// ==== hdl/render_sequencer.sv ====
`timescale 1ns/1ps

module render_sequencer (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 scored,
	input  logic                 frame_tick,
	input  logic                 fill_done,
	input  logic                 paddle_done,
	input  logic                 ball_done,
	output pong_pkg::draw_step_t step,
	output logic                 frame_latch,
	output logic                 fill_start,
	output logic                 paddle_start,
	output logic                 ball_start
);

	import pong_pkg::*;

	draw_step_t state;
	draw_step_t state_next;

	// engine in flight, so an aborted box finishes before the clear starts
	logic fill_busy;
	logic paddle_busy;
	logic ball_busy;
	logic any_busy;

	logic enter_paddle;
	logic enter_ball;

	assign any_busy = fill_busy | paddle_busy | ball_busy;

	always_comb begin
		state_next = state;
		case (state)
			S_CLEAR_START: begin
				if (!any_busy) begin
					state_next = S_CLEAR_WAIT;
				end
			end
			S_CLEAR_WAIT: begin
				if (fill_done) begin
					state_next = S_IDLE;
				end
			end
			S_IDLE: begin
				if (frame_tick) begin
					state_next = S_ERASE_P1;
				end
			end
			S_ERASE_P1: begin
				if (paddle_done) begin
					state_next = S_DRAW_P1;
				end
			end
			S_DRAW_P1: begin
				if (paddle_done) begin
					state_next = S_ERASE_P2;
				end
			end
			S_ERASE_P2: begin
				if (paddle_done) begin
					state_next = S_DRAW_P2;
				end
			end
			S_DRAW_P2: begin
				if (paddle_done) begin
					state_next = S_ERASE_BALL;
				end
			end
			S_ERASE_BALL: begin
				if (ball_done) begin
					state_next = S_DRAW_BALL;
				end
			end
			S_DRAW_BALL: begin
				if (ball_done) begin
					state_next = S_IDLE;
				end
			end
			default: begin
				state_next = S_CLEAR_START;
			end
		endcase
		// a score restarts everything from a black screen
		if (scored) begin
			state_next = S_CLEAR_START;
		end
	end

	assign enter_paddle = (state_next != state) &&
		(state_next inside {S_ERASE_P1, S_DRAW_P1, S_ERASE_P2, S_DRAW_P2});
	assign enter_ball = (state_next != state) &&
		(state_next inside {S_ERASE_BALL, S_DRAW_BALL});

	// snapshot taken on the edge that leaves idle, ahead of the first box start
	assign frame_latch = (state == S_IDLE) && frame_tick && !scored;
	assign fill_start = (state == S_CLEAR_START) && !scored && !any_busy;
	assign step = state;

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= S_CLEAR_START;
			paddle_start <= 1'b0;
			ball_start <= 1'b0;
		end else begin
			state <= state_next;
			// box starts land on the first cycle of the new step
			paddle_start <= enter_paddle;
			ball_start <= enter_ball;
		end
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			fill_busy <= 1'b0;
			paddle_busy <= 1'b0;
			ball_busy <= 1'b0;
		end else begin
			if (fill_start) begin
				fill_busy <= 1'b1;
			end else if (fill_done) begin
				fill_busy <= 1'b0;
			end
			if (paddle_start) begin
				paddle_busy <= 1'b1;
			end else if (paddle_done) begin
				paddle_busy <= 1'b0;
			end
			if (ball_start) begin
				ball_busy <= 1'b1;
			end else if (ball_done) begin
				ball_busy <= 1'b0;
			end
		end
	end

	// no done may come back on a start cycle, so starts never land back to back
	a_start_pulse: assert property (@(posedge clk) disable iff (!resetn)
		(fill_start || paddle_start || ball_start) |=>
			!(fill_start || paddle_start || ball_start));

endmodule

// ==== hdl/screen_filler.sv ====
`timescale 1ns/1ps

module screen_filler #(
	parameter int SCREEN_W = 320,
	parameter int SCREEN_H = 240
) (
	input  logic               clk,
	input  logic               resetn,
	input  logic               start,
	output pong_pkg::coord_x_t px,
	output pong_pkg::coord_y_t py,
	output logic               active,
	output logic               done
);

	import pong_pkg::*;

	logic last_x;
	logic last_y;

	assign last_x = (px == coord_x_t'(SCREEN_W - 1));
	assign last_y = (py == coord_y_t'(SCREEN_H - 1));

	// raster scan from the top left corner
	always_ff @(posedge clk) begin
		if (!resetn) begin
			active <= 1'b0;
			px <= '0;
			py <= '0;
		end else if (start) begin
			active <= 1'b1;
			px <= '0;
			py <= '0;
		end else if (active) begin
			if (last_x) begin
				px <= '0;
				if (last_y) begin
					active <= 1'b0;
				end else begin
					py <= py + 1'b1;
				end
			end else begin
				px <= px + 1'b1;
			end
		end
	end

	assign done = active && last_x && last_y;

endmodule

// ==== src.f ====
hdl/pong_pkg.sv
hdl/frame_timer.sv
hdl/render_sequencer.sv
hdl/position_store.sv
hdl/box_plotter.sv
hdl/screen_filler.sv
hdl/pixel_output.sv
hdl/pong_display.sv
tests/pong_display_tb.sv

// ==== tests/pong_display_tb.sv ====
`timescale 1ns/1ps

module pong_display_tb;

	import pong_pkg::*;

	localparam int SCREEN_W = 32;
	localparam int SCREEN_H = 24;
	localparam int PADDLE_W = 2;
	localparam int PADDLE_H = 6;
	localparam int BALL_W = 2;
	localparam int BALL_H = 2;
	localparam int PADDLE1_X = 1;
	localparam int PADDLE2_X = SCREEN_W - PADDLE_W;
	localparam int SCREEN_PIXELS = SCREEN_W * SCREEN_H;
	localparam int FRAME_PIXELS = 4 * PADDLE_W * PADDLE_H + 2 * BALL_W * BALL_H;
	// ball stays clear of both paddle columns, so its erase never cuts into a paddle
	localparam int BALL_X_MIN = PADDLE1_X + PADDLE_W;
	localparam int BALL_X_MAX = PADDLE2_X - BALL_W;

	logic clk;
	logic resetn;
	logic scored;
	coord_y_t paddle1_y;
	coord_y_t paddle2_y;
	coord_x_t ball_x;
	coord_y_t ball_y;
	coord_x_t pix_x;
	coord_y_t pix_y;
	colour_t pix_colour;
	logic plot;

	// screen model and what it should hold
	colour_t fb [SCREEN_PIXELS];
	colour_t expected_fb [SCREEN_PIXELS];
	int hits [SCREEN_PIXELS];
	int plot_count;
	int covered;
	int out_of_range;
	int nonblack_count;
	logic expect_black;
	int errors;
	int checks;
	logic timed_out;
	integer seed;

	pong_display #(
		.SCREEN_W(SCREEN_W),
		.SCREEN_H(SCREEN_H),
		.PADDLE_W(PADDLE_W),
		.PADDLE_H(PADDLE_H),
		.BALL_W(BALL_W),
		.BALL_H(BALL_H),
		.PADDLE1_X(PADDLE1_X),
		.CLOCKS_PER_FRAME(400)
	) pong_display_inst (
		.clk(clk), .resetn(resetn), .scored(scored),
		.paddle1_y(paddle1_y), .paddle2_y(paddle2_y), .ball_x(ball_x), .ball_y(ball_y),
		.pix_x(pix_x), .pix_y(pix_y), .pix_colour(pix_colour), .plot(plot)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic int pixel_index(input int x, input int y);
		return y * SCREEN_W + x;
	endfunction

	// sampled mid-cycle, where the registered outputs are settled
	always @(negedge clk) begin
		if (resetn && plot) begin
			plot_count++;
			if (int'(pix_x) >= SCREEN_W || int'(pix_y) >= SCREEN_H) begin
				out_of_range++;
			end else begin
				fb[pixel_index(pix_x, pix_y)] = pix_colour;
				if (hits[pixel_index(pix_x, pix_y)] == 0) begin
					covered++;
				end
				hits[pixel_index(pix_x, pix_y)]++;
			end
			if (expect_black && pix_colour !== COLOUR_BLACK) begin
				nonblack_count++;
			end
		end
	end

	task automatic step_clk();
		@(posedge clk);
		#2;
	endtask

	task automatic compare_colour(input colour_t got, input colour_t want, input string what);
		checks++;
		if (got !== want) begin
			errors++;
			$display("Fail at %0t ns: %s, got %0d, expected %0d", $time, what, got, want);
		end
	endtask

	task automatic compare_count(input int got, input int want, input string what);
		checks++;
		if (got !== want) begin
			errors++;
			$display("Fail at %0t ns: %s, got %0d, expected %0d", $time, what, got, want);
		end
	endtask

	task automatic report_timeout(input string what);
		errors++;
		timed_out = 1'b1;
		$display("timeout at %0t ns while waiting for %s", $time, what);
	endtask

	task automatic clear_tracking();
		plot_count = 0;
		covered = 0;
		nonblack_count = 0;
		for (int i = 0; i < SCREEN_PIXELS; i++) begin
			hits[i] = 0;
		end
	endtask

	task automatic wait_for_plot(input int limit);
		int n;
		n = 0;
		while (!plot && n < limit) begin
			step_clk();
			n++;
		end
		if (!plot) begin
			report_timeout("plot activity");
		end
	endtask

	task automatic wait_for_quiet(input int quiet, input int limit);
		int n;
		int low_run;
		n = 0;
		low_run = 0;
		while (low_run < quiet && n < limit) begin
			step_clk();
			n++;
			if (plot) begin
				low_run = 0;
			end else begin
				low_run++;
			end
		end
		if (low_run < quiet) begin
			report_timeout("plot to stay low");
		end
	endtask

	// the fill is one unbroken run, so it ends at the first low plot after full coverage
	task automatic wait_clear_done(input int limit);
		int n;
		n = 0;
		while (covered < SCREEN_PIXELS && n < limit) begin
			step_clk();
			n++;
		end
		if (covered < SCREEN_PIXELS) begin
			report_timeout("full screen coverage");
			return;
		end
		while (plot && n < limit) begin
			step_clk();
			n++;
		end
		if (plot) begin
			report_timeout("end of screen clear");
		end
	endtask

	task automatic set_positions(input int p1, input int p2, input int bx, input int by);
		paddle1_y = coord_y_t'(p1);
		paddle2_y = coord_y_t'(p2);
		ball_x = coord_x_t'(bx);
		ball_y = coord_y_t'(by);
	endtask

	task automatic clear_expected();
		for (int i = 0; i < SCREEN_PIXELS; i++) begin
			expected_fb[i] = COLOUR_BLACK;
		end
	endtask

	task automatic draw_box_expected(input int x0, input int y0, input int w, input int h,
		input colour_t colour);
		for (int y = y0; y < y0 + h; y++) begin
			for (int x = x0; x < x0 + w; x++) begin
				expected_fb[pixel_index(x, y)] = colour;
			end
		end
	endtask

	// picture from the latest positions only
	task automatic build_expected();
		clear_expected();
		draw_box_expected(PADDLE1_X, int'(paddle1_y), PADDLE_W, PADDLE_H, COLOUR_PADDLE);
		draw_box_expected(PADDLE2_X, int'(paddle2_y), PADDLE_W, PADDLE_H, COLOUR_PADDLE);
		draw_box_expected(int'(ball_x), int'(ball_y), BALL_W, BALL_H, COLOUR_BALL);
	endtask

	task automatic check_picture(input string what);
		for (int y = 0; y < SCREEN_H; y++) begin
			for (int x = 0; x < SCREEN_W; x++) begin
				compare_colour(fb[pixel_index(x, y)], expected_fb[pixel_index(x, y)],
					$sformatf("%s pixel (%0d,%0d)", what, x, y));
			end
		end
	endtask

	task automatic one_frame(input string what);
		clear_tracking();
		wait_for_plot(1000);
		if (timed_out) begin
			return;
		end
		wait_for_quiet(50, 1000);
		if (timed_out) begin
			return;
		end
		compare_count(plot_count, FRAME_PIXELS, {what, " plot count"});
		build_expected();
		check_picture(what);
	endtask

	task automatic clear_after_reset();
		wait_clear_done(2 * SCREEN_PIXELS);
		if (timed_out) begin
			return;
		end
		compare_count(plot_count, SCREEN_PIXELS, "plots in reset clear");
		for (int i = 0; i < SCREEN_PIXELS; i++) begin
			compare_count(hits[i], 1, $sformatf("writes to pixel %0d in reset clear", i));
		end
		clear_expected();
		check_picture("reset clear");
	endtask

	task automatic first_frame_draw();
		set_positions(5, 12, 14, 9);
		one_frame("first frame");
	endtask

	task automatic frames_with_random_positions(input int frames);
		int p1;
		int p2;
		int bx;
		int by;
		for (int f = 0; f < frames && !timed_out; f++) begin
			p1 = $unsigned($random(seed)) % (SCREEN_H - PADDLE_H + 1);
			p2 = $unsigned($random(seed)) % (SCREEN_H - PADDLE_H + 1);
			bx = BALL_X_MIN + $unsigned($random(seed)) % (BALL_X_MAX - BALL_X_MIN + 1);
			by = $unsigned($random(seed)) % (SCREEN_H - BALL_H + 1);
			set_positions(p1, p2, bx, by);
			one_frame($sformatf("random frame %0d", f));
		end
	endtask

	task automatic score_aborts_frame();
		set_positions(4, 10, 20, 3);
		clear_tracking();
		wait_for_plot(1000);
		if (timed_out) begin
			return;
		end
		// still inside the first paddle erase
		repeat (8) step_clk();
		scored = 1'b1;
		step_clk();
		scored = 1'b0;
		set_positions(15, 2, 6, 17);
		step_clk();
		clear_tracking();
		expect_black = 1'b1;
		wait_clear_done(2 * SCREEN_PIXELS);
		expect_black = 1'b0;
		if (timed_out) begin
			return;
		end
		compare_count(nonblack_count, 0, "coloured plots during score clear");
		clear_expected();
		check_picture("score clear");
		one_frame("frame after score");
	endtask

	initial begin
		resetn = 1'b0;
		scored = 1'b0;
		paddle1_y = '0;
		paddle2_y = '0;
		ball_x = '0;
		ball_y = '0;
		errors = 0;
		checks = 0;
		out_of_range = 0;
		expect_black = 1'b0;
		timed_out = 1'b0;
		seed = 18354;
		clear_tracking();
		repeat (2) @(posedge clk);
		#2;
		resetn = 1'b1;

		clear_after_reset();
		if (!timed_out) begin
			first_frame_draw();
		end
		if (!timed_out) begin
			frames_with_random_positions(5);
		end
		if (!timed_out) begin
			score_aborts_frame();
		end
		compare_count(out_of_range, 0, "plots outside the screen");

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule
